// ==== design/board_pos.sv ====
`timescale 1ns/1ns

module board_pos (
  input  logic    clk,
  input  logic    arst_n,
  step_if.tracker trk
);

  import knight_pkg::*;

  // Positions reached moving in the positive direction, one bit wider
  logic [4:0] reach_x;
  logic [4:0] reach_y;

  ////////////////////////////////////////////////////////////////////////////
  // Fit check
  ////////////////////////////////////////////////////////////////////////////

  assign reach_x = {2'b00, trk.xx} + {1'b0, trk.squares};
  assign reach_y = {2'b00, trk.yy} + {1'b0, trk.squares};

  // North and east grow a coordinate, west and south shrink one
  always_comb begin
    trk.fits = 1'b0;
    case (trk.dir)
      dir_north: trk.fits = (reach_y <= {2'b00, board_max});
      dir_east:  trk.fits = (reach_x <= {2'b00, board_max});
      // Shrinking moves fit as long as the distance does not pass zero
      dir_south: trk.fits = (trk.squares <= {1'b0, trk.yy});
      dir_west:  trk.fits = (trk.squares <= {1'b0, trk.xx});
      default:   trk.fits = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Position register
  ////////////////////////////////////////////////////////////////////////////

  // The knight moves a single square per step strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trk.xx <= start_x;
      trk.yy <= start_y;
    end else if (trk.step) begin
      case (trk.dir)
        dir_north: trk.yy <= trk.yy + 3'd1;
        dir_south: trk.yy <= trk.yy - 3'd1;
        dir_east:  trk.xx <= trk.xx + 3'd1;
        dir_west:  trk.xx <= trk.xx - 3'd1;
        default: begin
          trk.xx <= trk.xx;
          trk.yy <= trk.yy;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Stepping past an edge wraps the 3-bit count above board_max
  a_on_board : assert property (@(posedge clk) disable iff (!arst_n)
    trk.step |=> (trk.xx <= board_max) && (trk.yy <= board_max))
    else $error("knight stepped off the board to (%0d,%0d)", trk.xx, trk.yy);

endmodule

// ==== design/cmd_seq.sv ====
`timescale 1ns/1ns

module cmd_seq (
  input  logic                         clk,
  input  logic                         arst_n,
  input  knight_pkg::cmd_word_u        cmd,
  input  logic                         cmd_rdy,
  step_if.seq                          trk,
  output logic                         load,
  output logic [knight_pkg::cnt_w-1:0] load_val,
  input  logic                         expired,
  output logic [7:0]                   resp,
  output logic                         resp_rdy,
  output logic                         moving,
  output logic                         cal_done
);

  import knight_pkg::*;

  seq_state_t state;

  // Squares still to travel in the current move
  logic [3:0] rem;

  // Direction latched for the whole move, and the pending reply type
  dir_t dir_q;
  logic nak_q;

  // Set while a calibration reply is waiting to go out
  logic cal_pend;

  // Decoded view of the incoming word
  dir_t hdg_dir;
  logic hdg_ok;
  logic is_cal;
  logic is_move;
  logic start_cmd;
  logic start_timed;

  ////////////////////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////////////////////

  // Only the four cardinal heading bytes are legal
  always_comb begin
    hdg_ok  = 1'b1;
    hdg_dir = dir_north;
    case (cmd.move_view.heading)
      hdg_north: hdg_dir = dir_north;
      hdg_west:  hdg_dir = dir_west;
      hdg_south: hdg_dir = dir_south;
      hdg_east:  hdg_dir = dir_east;
      default:   hdg_ok  = 1'b0;
    endcase
  end

  // Calibration requires the reserved field to be clear
  assign is_cal = (cmd.cal_view.opcode == op_cal) && (cmd.cal_view.rsvd == 12'h000);

  // A move is only legal once calibrated and when the path stays on the board
  assign is_move = (cmd.move_view.opcode == op_move) && cal_done && hdg_ok && trk.fits;

  assign start_cmd = (state == st_idle) && cmd_rdy;

  // Calibration and nonzero moves both need the timer, zero moves reply at once
  assign start_timed = start_cmd &&
                       (is_cal || (is_move && (cmd.move_view.squares != 4'd0)));

  // While idle the tracker evaluates the incoming request, later the remainder
  assign trk.dir     = (state == st_idle) ? hdg_dir : dir_q;
  assign trk.squares = (state == st_idle) ? cmd.move_view.squares : rem;

  // Each expiry in move is one square completed
  assign trk.step = (state == st_move) && expired;

  // Reload on every square boundary except the last one
  assign load = start_timed || (trk.step && (rem != 4'd1));

  assign load_val = (start_cmd && is_cal) ? cal_cycles : square_cycles;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      rem      <= 4'd0;
      cal_pend <= 1'b0;
      resp     <= 8'h00;
      resp_rdy <= 1'b0;
      moving   <= 1'b0;
      cal_done <= 1'b0;
    end else begin
      resp_rdy <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_rdy) begin
            if (is_cal) begin
              state    <= st_calib;
            end else if (start_timed) begin
              state    <= st_move;
              rem      <= cmd.move_view.squares;
              moving   <= 1'b1;
            end else begin
              // Illegal words and zero-square moves go straight to the reply
              state    <= st_respond;
            end
          end
        end
        st_calib: begin
          if (expired) begin
            state    <= st_respond;
            cal_pend <= 1'b1;
          end
        end
        st_move: begin
          if (expired) begin
            rem <= rem - 4'd1;
            if (rem == 4'd1) begin
              state <= st_respond;
            end
          end
        end
        st_respond: begin
          // Reply, cal_done and the end of motion all appear on the same edge
          resp     <= nak_q ? resp_nak : resp_ack;
          resp_rdy <= 1'b1;
          moving   <= 1'b0;
          if (cal_pend) begin
            cal_done <= 1'b1;
          end
          cal_pend <= 1'b0;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Direction and reply type are captured from the accepted word
  always_ff @(posedge clk) begin
    if (start_cmd) begin
      dir_q <= hdg_dir;
      nak_q <= !(is_cal || is_move);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Every reply is a single-cycle pulse
  a_resp_pulse : assert property (@(posedge clk) disable iff (!arst_n)
    resp_rdy |=> !resp_rdy)
    else $error("resp_rdy held for two cycles, state %s", state.name());

  // The tracker is only stepped during an accepted move with squares still to go
  a_step_in_move : assert property (@(posedge clk) disable iff (!arst_n)
    trk.step |-> moving && (rem != 4'd0))
    else $error("step pulsed outside a move, state %s", state.name());

endmodule

// ==== design/knight_ctrl.sv ====
`timescale 1ns/1ns

module knight_ctrl (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] cmd,
  input  logic        cmd_rdy,
  output logic [7:0]  resp,
  output logic        resp_rdy,
  output logic        moving,
  output logic        cal_done,
  output logic [2:0]  xx,
  output logic [2:0]  yy
);

  import knight_pkg::*;

  // Timer control between the sequencer and the square timer
  logic             load;
  logic [cnt_w-1:0] load_val;
  logic             expired;

  // Step requests and position feedback
  step_if trk ();

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  cmd_seq i_seq (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy),
    .trk      (trk.seq),
    .load     (load),
    .load_val (load_val),
    .expired  (expired),
    .resp     (resp),
    .resp_rdy (resp_rdy),
    .moving   (moving),
    .cal_done (cal_done)
  );

  // Times calibration and every square of travel
  square_timer i_timer (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (load),
    .load_val (load_val),
    .expired  (expired)
  );

  board_pos i_board (
    .clk    (clk),
    .arst_n (arst_n),
    .trk    (trk.tracker)
  );

  // The position comes straight from the tracker register
  assign xx = trk.xx;
  assign yy = trk.yy;

endmodule

// ==== design/knight_pkg.sv ====
package knight_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command and response encodings
  ////////////////////////////////////////////////////////////////////////////

  // Opcodes sit in the top nibble of every command word
  localparam logic [3:0] op_cal  = 4'h2;
  localparam logic [3:0] op_move = 4'h4;

  // Single-byte replies returned to the remote link
  localparam logic [7:0] resp_ack = 8'hA5;
  localparam logic [7:0] resp_nak = 8'hEE;

  // Top byte of the 12-bit heading for each of the four legal directions
  localparam logic [7:0] hdg_north = 8'h00;
  localparam logic [7:0] hdg_west  = 8'h3F;
  localparam logic [7:0] hdg_south = 8'h7F;
  localparam logic [7:0] hdg_east  = 8'hC0;

  ////////////////////////////////////////////////////////////////////////////
  // Board geometry and timing
  ////////////////////////////////////////////////////////////////////////////

  // The board is 5 by 5, so both coordinates run from 0 to 4
  localparam logic [2:0] board_max = 3'd4;
  localparam logic [2:0] start_x   = 3'd2;
  localparam logic [2:0] start_y   = 3'd2;

  // Timer width covers the longer of the two phases
  localparam int cnt_w = 7;

  // Shortened durations so that simulation runs in a few thousand cycles
  localparam logic [cnt_w-1:0] cal_cycles    = 7'd64;
  localparam logic [cnt_w-1:0] square_cycles = 7'd32;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Internal direction code, decoded from one of the heading bytes
  typedef enum logic [1:0] {dir_north, dir_west, dir_south, dir_east} dir_t;

  // One 16-bit command word read either as a calibrate or as a move
  typedef union packed {
    struct packed {
      logic [3:0]  opcode;
      logic [11:0] rsvd;
    } cal_view;
    struct packed {
      logic [3:0] opcode;
      logic [7:0] heading;
      logic [3:0] squares;
    } move_view;
  } cmd_word_u;

  // Command sequencer states
  typedef enum logic [1:0] {st_idle, st_calib, st_move, st_respond} seq_state_t;

endpackage

// ==== design/square_timer.sv ====
`timescale 1ns/1ns

module square_timer (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         load,
  input  logic [knight_pkg::cnt_w-1:0] load_val,
  output logic                         expired
);

  import knight_pkg::*;

  // Remaining cycles minus one, so zero marks the final cycle
  logic [cnt_w-1:0] cnt;
  logic             running;

  // Expiry lands exactly load_val cycles after the loading edge
  assign expired = running && (cnt == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      running <= 1'b0;
    end else if (load) begin
      // A load on the expiry cycle chains straight into the next period
      cnt     <= load_val - 1'b1;
      running <= 1'b1;
    end else if (running) begin
      if (cnt == '0) begin
        running <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // The sequencer may only reload when the previous period has just ended
  a_no_early_load : assert property (@(posedge clk) disable iff (!arst_n)
    load |-> (!running || expired))
    else $error("timer reloaded with %0d cycles still to run", cnt);

  // A zero-length period would never expire
  a_load_nonzero : assert property (@(posedge clk) disable iff (!arst_n)
    load |-> (load_val != '0))
    else $error("timer loaded with zero");

endmodule

// ==== design/step_if.sv ====
`timescale 1ns/1ns

// Link between the command sequencer and the board tracker
interface step_if;

  import knight_pkg::*;

  // Requested direction, and the distance that fits is evaluated for
  dir_t       dir;
  logic [3:0] squares;

  // One-cycle strobe that advances the knight by one square
  logic       step;

  // Current knight position
  logic [2:0] xx;
  logic [2:0] yy;

  // High when the requested distance stays on the board
  logic       fits;

  modport seq (
    output dir, squares, step,
    input  xx, yy, fits
  );

  modport tracker (
    input  dir, squares, step,
    output xx, yy, fits
  );

endinterface

// ==== run.sh ====
#!/bin/sh
# Builds the knight controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module knight_ctrl_tb -o knight_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/knight_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== src.f ====
+incdir+verif
design/knight_pkg.sv
design/step_if.sv
design/cmd_seq.sv
design/square_timer.sv
design/board_pos.sv
design/knight_ctrl.sv
verif/knight_ctrl_tb.sv

// ==== verif/knight_ref.svh ====
`ifndef knight_ref_svh
`define knight_ref_svh

// Expected outcome of one command, packed as {calibrated, resp, x, y}
function automatic logic [14:0] ref_step(input logic [15:0] word, input logic calibrated,
                                         input logic [2:0] px, input logic [2:0] py);
  int         x;
  int         y;
  int         n;
  logic       legal;
  logic       cal_after;
  logic [7:0] r;
  x         = int'(px);
  y         = int'(py);
  n         = int'(word[3:0]);
  legal     = 1'b1;
  cal_after = calibrated;
  r         = resp_nak;
  if (word[15:12] == op_cal && word[11:0] == 12'h000) begin
    cal_after = 1'b1;
    r         = resp_ack;
  end else if (word[15:12] == op_move && calibrated) begin
    // North and east count up, south and west count down
    case (word[11:4])
      hdg_north: y = y + n;
      hdg_south: y = y - n;
      hdg_east:  x = x + n;
      hdg_west:  x = x - n;
      default:   legal = 1'b0;
    endcase
    if (legal && x >= 0 && x <= int'(board_max) && y >= 0 && y <= int'(board_max)) begin
      r = resp_ack;
    end
  end
  // A refused move leaves the knight where it was
  if (r == resp_nak) begin
    x = int'(px);
    y = int'(py);
  end
  return {cal_after, r, 3'(x), 3'(y)};
endfunction

// Falling edges from the strobe edge to the edge where the reply is seen
function automatic int ref_latency(input logic [15:0] word, input logic [7:0] r);
  if (r == resp_ack && word[15:12] == op_cal) begin
    return int'(cal_cycles) + 2;
  end
  if (r == resp_ack && word[15:12] == op_move) begin
    return int'(word[3:0]) * int'(square_cycles) + 2;
  end
  return 2;
endfunction

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

// ==== verif/knight_ctrl_tb.sv ====
`timescale 1ns/1ns

module knight_ctrl_tb;

  import knight_pkg::*;

  `include "knight_ref.svh"

  localparam int clk_half   = 4;
  localparam int n_directed = 12;
  localparam int n_random   = 40;
  // Longest possible reply, a full 4-bit square count
  localparam int worst_cycles    = 15 * int'(square_cycles) + 2;
  localparam int busy_tail       = 4 * int'(square_cycles) + 8;
  localparam int watchdog_cycles = (n_directed + n_random) * (worst_cycles + 4)
                                   + busy_tail + 200;
  localparam logic [15:0] lfsr_seed = 16'd45;

  logic        clk;
  logic        arst_n;
  logic [15:0] cmd;
  logic        cmd_rdy;
  logic [7:0]  resp;
  logic        resp_rdy;
  logic        moving;
  logic        cal_done;
  logic [2:0]  xx;
  logic [2:0]  yy;

  int          cyc = 0;
  logic [15:0] lfsr = lfsr_seed;

  // Commands in flight, oldest first, with the cycle of their strobe
  logic [15:0] word_q[$];
  string       name_q[$];
  int          cyc_q[$];

  // Model state, only touched by the compare process
  logic        ref_cal = 1'b0;
  logic [2:0]  ref_x = start_x;
  logic [2:0]  ref_y = start_y;

  int n_checked    = 0;
  int n_value_err  = 0;
  int n_timing_err = 0;
  int n_proto_err  = 0;

  knight_ctrl i_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy),
    .resp     (resp),
    .resp_rdy (resp_rdy),
    .moving   (moving),
    .cal_done (cal_done),
    .xx       (xx),
    .yy       (yy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_half) clk = ~clk;
  end

  // Cycle count, stable whenever it is read on a falling edge
  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Steps the LFSR once per bit and shifts each new low bit in
  function automatic logic [15:0] draw_bits(input int n);
    logic [15:0] v;
    v = 16'h0000;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Presents one word with a single-cycle strobe and queues it for the checker
  task automatic send(input string test, input logic [15:0] word);
    @(negedge clk);
    word_q.push_back(word);
    name_q.push_back(test);
    cyc_q.push_back(cyc);
    cmd     = word;
    cmd_rdy = 1'b1;
    @(negedge clk);
    cmd_rdy = 1'b0;
  endtask

  task automatic issue(input string test, input logic [15:0] word);
    int waited;
    send(test, word);
    waited = 1;
    while (!resp_rdy && waited < worst_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_rdy) begin
      $display("Test %s got no response within %0d cycles", test, worst_cycles);
      n_proto_err++;
    end
    repeat (2) @(negedge clk);
  endtask

  // Sends a move, then a stray strobe part way through, watching moving
  task automatic issue_while_busy(input string test, input logic [15:0] word,
                                  input logic [15:0] intruder);
    int waited;
    send(test, word);
    waited = 1;
    while (!resp_rdy && waited < worst_cycles) begin
      if (moving !== 1'b1) begin
        $display("ERROR %s: moving expected 1 actual %b at cycle %0d", test, moving, cyc);
        n_value_err++;
      end
      cmd     = intruder;
      cmd_rdy = (waited == 10);
      @(negedge clk);
      waited++;
    end
    cmd_rdy = 1'b0;
    if (moving !== 1'b0) begin
      $display("ERROR %s: moving at response expected 0 actual %b", test, moving);
      n_value_err++;
    end
    // Long enough for the stray command to answer, had it been accepted
    repeat (busy_tail) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare_responses
    logic [14:0] model;
    logic [15:0] word;
    string       name;
    int          t0;
    int          lat;
    forever begin
      @(negedge clk);
      if (arst_n && resp_rdy) begin
        if (word_q.size() == 0) begin
          $display("Response %0h arrived with no command outstanding, cycle %0d", resp, cyc);
          n_proto_err++;
        end else begin
          word  = word_q.pop_front();
          name  = name_q.pop_front();
          t0    = cyc_q.pop_front();
          model = ref_step(word, ref_cal, ref_x, ref_y);
          lat   = ref_latency(word, model[13:6]);
          if (resp !== model[13:6]) begin
            $display("ERROR %s: resp expected %0h actual %0h", name, model[13:6], resp);
            n_value_err++;
          end
          if ({xx, yy} !== model[5:0]) begin
            $display("ERROR %s: position expected (%0d,%0d) actual (%0d,%0d)",
                     name, model[5:3], model[2:0], xx, yy);
            n_value_err++;
          end
          if (cal_done !== model[14]) begin
            $display("ERROR %s: cal_done expected %b actual %b", name, model[14], cal_done);
            n_value_err++;
          end
          if (cyc - t0 != lat) begin
            $display("ERROR %s: latency expected %0d actual %0d", name, lat, cyc - t0);
            n_timing_err++;
          end
          ref_cal = model[14];
          ref_x   = model[5:3];
          ref_y   = model[2:0];
          n_checked++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog ran out after %0d cycles, the run did not finish", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    logic [15:0] word;
    logic [7:0]  hdg;
    logic [3:0]  sq;
    logic [2:0]  hsel;
    logic [1:0]  osel;
    int          total;
    arst_n  = 1'b0;
    cmd     = 16'h0000;
    cmd_rdy = 1'b0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    if ({resp_rdy, moving, cal_done} !== 3'b000) begin
      $display("ERROR reset: flags expected 000 actual %b", {resp_rdy, moving, cal_done});
      n_value_err++;
    end
    if (resp !== 8'h00) begin
      $display("ERROR reset: resp expected 0 actual %0h", resp);
      n_value_err++;
    end
    if (xx !== start_x || yy !== start_y) begin
      $display("ERROR reset: position expected (%0d,%0d) actual (%0d,%0d)",
               start_x, start_y, xx, yy);
      n_value_err++;
    end

    // Directed cases walk the knight (2,2) (2,3) (0,3) (0,1) (4,1)
    issue("move_before_cal", 16'h4001);
    issue("cal_reserved_set", 16'h2001);
    issue("calibrate", 16'h2000);
    issue("north_one", 16'h4001);
    issue("north_off_board", 16'h4002);
    issue("undefined_heading", 16'h4121);
    issue("zero_squares", 16'h4C00);
    issue("undefined_opcode", 16'h7001);
    issue("west_two", 16'h43F2);
    issue("west_off_board", 16'h43F1);
    issue_while_busy("busy_south_two", 16'h47F2, 16'h4C04);
    issue("east_four", 16'h4C04);

    // Mix of moves, calibrates and stray opcodes, squares 0 to 5
    for (int i = 0; i < n_random; i++) begin
      osel = 2'(draw_bits(2));
      hsel = 3'(draw_bits(3));
      sq   = 4'(draw_bits(3) % 16'd6);
      case (hsel)
        3'd0:    hdg = hdg_north;
        3'd1:    hdg = hdg_west;
        3'd2:    hdg = hdg_south;
        3'd3:    hdg = hdg_east;
        default: hdg = 8'(draw_bits(8));
      endcase
      case (osel)
        2'd0, 2'd1: word = {op_move, hdg, sq};
        2'd2: begin
          if (draw_bits(1) == 16'd1) begin
            word = {op_cal, hdg, sq};
          end else begin
            word = {op_cal, 12'h000};
          end
        end
        default: word = {4'(draw_bits(4)), hdg, sq};
      endcase
      issue($sformatf("random_%0d", i), word);
    end

    repeat (8) @(negedge clk);
    if (n_checked != n_directed + n_random) begin
      $display("Only %0d of %0d commands received a response", n_checked,
               n_directed + n_random);
      n_proto_err++;
    end
    total = n_value_err + n_timing_err + n_proto_err;
    $display("Summary: %0d responses checked, %0d value errors, %0d timing errors, %0d other",
             n_checked, n_value_err, n_timing_err, n_proto_err);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
